/* dcache_config.svh */
////////////////////////////////////////
// data cache geometry and bus widths
// 2 ways x 16 sets x 16 byte lines
////////////////////////////////////////
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define DC_ADDR_W   32   // cpu and memory address
`define DC_DATA_W   64   // one doubleword, one memory beat
`define DC_LINE_W   128  // two beats per line
`define DC_WAYS     2
`define DC_SETS     16
`define DC_INDEX_W  4
`define DC_OFFSET_W 4    // byte inside the line
`define DC_TAG_W    24   // addr - index - offset
`define DC_WAY_W    1    // way number width
`define DC_CNT_W    32   // hit and miss counters

`endif

/* dcache_pkg.sv */
////////////////////////////////////////
// shared types for the data cache
////////////////////////////////////////
`default_nettype none
`include "dcache_config.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        SZ_B,  // 1 byte
        SZ_H,  // 2 bytes
        SZ_W,  // 4 bytes
        SZ_D   // 8 bytes
    } dc_size_e;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic                  we;     // 1 store, 0 load
        dc_size_e              size;
        logic [`DC_DATA_W-1:0] wdata;  // right aligned
    } cpu_req_t;

    // one 64-bit memory beat
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;   // beat aligned
        logic                  we;
        logic [`DC_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_WBACK, ST_REFILL, ST_DONE, ST_RELEASE
    } dc_state_e;

    typedef enum logic {
        BURST_REFILL,
        BURST_WBACK
    } dc_burst_e;

endpackage

`default_nettype wire

/* dcache_tag_array.sv */
////////////////////////////////////////
// tag, valid and dirty storage
// parallel way compare, random victim
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_tag_array (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_TAG_W-1:0]   tag_i,
    input  logic                   we_i,         // fill: new tag, valid
    input  logic [`DC_WAY_W-1:0]   way_i,
    input  logic                   dirty_set_i,
    input  logic                   dirty_clr_i,
    input  logic                   hold_i,       // freeze victim counter
    output logic                   hit_o,
    output logic [`DC_WAY_W-1:0]   hit_way_o,
    output logic [`DC_WAY_W-1:0]   victim_way_o,
    output logic                   victim_dirty_o,
    output logic [`DC_TAG_W-1:0]   victim_tag_o
);
    logic [`DC_TAG_W-1:0] tag_q [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]  valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]  dirty_q [`DC_SETS];
    logic [`DC_WAYS-1:0]  way_hit;
    logic [`DC_WAY_W-1:0] victim_q;

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
            if (way_hit[w]) hit_way_o = w[`DC_WAY_W-1:0];
        end
    end

    assign hit_o          = |way_hit;
    assign victim_way_o   = victim_q;
    assign victim_tag_o   = tag_q[index_i][victim_q];
    assign victim_dirty_o = valid_q[index_i][victim_q] && dirty_q[index_i][victim_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (we_i) valid_q[index_i][way_i] <= 1'b1;
            if (dirty_clr_i)      dirty_q[index_i][way_i] <= 1'b0;  // fresh line is clean
            else if (dirty_set_i) dirty_q[index_i][way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) tag_q[index_i][way_i] <= tag_i;
    end

    // free running pseudo random replacement
    always_ff @(posedge clk) begin
        if (rst)          victim_q <= '0;
        else if (!hold_i) victim_q <= victim_q + 1'b1;
    end

    a_one_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
        else $error("tag hit in more than one way");

endmodule

`default_nettype wire

/* dcache_data_array.sv */
////////////////////////////////////////
// line storage, byte enable writes
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_data_array (
    input  logic                      clk,
    input  logic [`DC_INDEX_W-1:0]    index_i,
    input  logic [`DC_WAY_W-1:0]      way_i,
    input  logic                      we_i,
    input  logic [`DC_LINE_W/8-1:0]   byte_en_i,
    input  logic [`DC_LINE_W-1:0]     wdata_i,
    output logic [`DC_LINE_W-1:0]     rdata_o
);
    localparam int BYTES = `DC_LINE_W / 8;

    logic [`DC_LINE_W-1:0]  mem_q [`DC_SETS][`DC_WAYS];
    logic [`DC_INDEX_W-1:0] index_q;  // set of the access in flight

    always_ff @(posedge clk) begin
        index_q <= index_i;
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < BYTES; b++) begin
                if (byte_en_i[b]) mem_q[index_q][way_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    assign rdata_o = mem_q[index_q][way_i];  // async read, also feeds write-back

endmodule

`default_nettype wire

/* dcache_align.sv */
////////////////////////////////////////
// load extraction and store merge
// by access size and byte offset
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_align (
    input  dcache_pkg::cpu_req_t    req_i,
    input  logic [`DC_LINE_W-1:0]   line_i,
    input  logic [`DC_LINE_W-1:0]   refill_line_i,
    input  logic                    fill_sel_i,     // whole line from memory
    output logic [`DC_LINE_W/8-1:0] byte_en_o,
    output logic [`DC_LINE_W-1:0]   wline_o,
    output logic [`DC_DATA_W-1:0]   rdata_o
);
    localparam int WBYTES = `DC_DATA_W / 8;

    logic [`DC_OFFSET_W-1:0] off;
    logic [WBYTES-1:0]       size_be;    // bytes touched, unshifted
    logic [`DC_DATA_W-1:0]   size_mask;
    logic [`DC_LINE_W-1:0]   line_shr;

    assign off = req_i.addr[`DC_OFFSET_W-1:0];

    always_comb begin
        case (req_i.size)
            dcache_pkg::SZ_B: size_be = 8'h01;
            dcache_pkg::SZ_H: size_be = 8'h03;
            dcache_pkg::SZ_W: size_be = 8'h0f;
            dcache_pkg::SZ_D: size_be = 8'hff;
        endcase
        for (int b = 0; b < WBYTES; b++) begin
            size_mask[b*8 +: 8] = {8{size_be[b]}};
        end
    end

    // aligned accesses never cross the doubleword
    assign byte_en_o = fill_sel_i ? '1 : {{WBYTES{1'b0}}, size_be} << off;
    assign wline_o   = fill_sel_i ? refill_line_i
                                  : {{`DC_DATA_W{1'b0}}, req_i.wdata} << {off, 3'b000};

    assign line_shr = line_i >> {off, 3'b000};
    assign rdata_o  = line_shr[`DC_DATA_W-1:0] & size_mask;  // zero extend

endmodule

`default_nettype wire

/* dcache_mem_port.sv */
////////////////////////////////////////
// two beat burst sequencer
// refill and write-back over req/ack
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_mem_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  dcache_pkg::dc_burst_e  kind_i,
    input  logic [`DC_ADDR_W-1:0]  line_addr_i,
    input  logic [`DC_LINE_W-1:0]  wb_line_i,
    output dcache_pkg::mem_req_t   mem_req_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_ack_i,
    input  logic [`DC_DATA_W-1:0]  mem_rdata_i,
    output logic                   done_o,
    output logic [`DC_LINE_W-1:0]  refill_line_o
);
    logic                   busy_q;
    logic                   valid_q;
    logic                   beat_q;    // 0 low doubleword, 1 high
    logic                   done_q;
    dcache_pkg::dc_burst_e  kind_q;
    logic [`DC_ADDR_W-1:0]  addr_q;
    logic [`DC_LINE_W-1:0]  line_q;    // write-back data, then refill data

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            beat_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                valid_q <= 1'b1;
                beat_q  <= 1'b0;
            end else if (valid_q) begin
                if (mem_ack_i) valid_q <= 1'b0;   // phase 2 seen, drop req
            end else if (busy_q && !mem_ack_i) begin  // ack gone, beat closed
                if (beat_q) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    beat_q  <= 1'b1;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            kind_q <= kind_i;
            addr_q <= line_addr_i;
            line_q <= wb_line_i;
        end else if (valid_q && mem_ack_i && kind_q == dcache_pkg::BURST_REFILL) begin
            if (beat_q) line_q[`DC_DATA_W +: `DC_DATA_W] <= mem_rdata_i;
            else        line_q[0 +: `DC_DATA_W]          <= mem_rdata_i;
        end
    end

    always_comb begin
        mem_req_o.addr  = {addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], beat_q,
                           {(`DC_OFFSET_W-1){1'b0}}};  // line + 0 or + 8
        mem_req_o.we    = (kind_q == dcache_pkg::BURST_WBACK);
        mem_req_o.wdata = beat_q ? line_q[`DC_DATA_W +: `DC_DATA_W] : line_q[0 +: `DC_DATA_W];
    end

    assign mem_req_valid_o = valid_q;
    assign done_o          = done_q;
    assign refill_line_o   = line_q;

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid_o && $past(mem_req_valid_o)) |-> $stable(mem_req_o))
        else $error("mem request changed while valid");

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
////////////////////////////////////////
// data cache controller
// cpu four-phase handshake, miss sequencing
// and hit/miss counters
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::cpu_req_t   req_i,
    input  logic                   cpu_req_valid_i,
    output logic                   cpu_ack_o,
    input  logic                   hit_i,
    input  logic [`DC_WAY_W-1:0]   hit_way_i,
    input  logic [`DC_WAY_W-1:0]   victim_way_i,
    input  logic                   victim_dirty_i,
    input  logic [`DC_TAG_W-1:0]   victim_tag_i,
    input  logic                   burst_done_i,
    output logic                   burst_start_o,
    output dcache_pkg::dc_burst_e  burst_kind_o,
    output logic [`DC_ADDR_W-1:0]  line_addr_o,
    output logic [`DC_WAY_W-1:0]   way_o,
    output logic                   hold_o,
    output logic                   tag_we_o,
    output logic                   dirty_set_o,
    output logic                   data_we_o,
    output logic                   fill_sel_o,
    output logic [`DC_CNT_W-1:0]   hit_count_o,
    output logic [`DC_CNT_W-1:0]   miss_count_o
);
    dcache_pkg::dc_state_e   state_q, state_d;
    logic                    ack_q;
    logic                    missed_q;   // access already counted as a miss
    logic                    in_lookup;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_TAG_W-1:0]    req_tag;
    logic [`DC_TAG_W-1:0]    burst_tag;

    assign in_lookup = (state_q == dcache_pkg::ST_LOOKUP);
    assign index     = req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag   = req_i.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    // miss: dirty victim goes out first, refill follows on its done
    assign burst_start_o = (in_lookup && !hit_i)
                         || (state_q == dcache_pkg::ST_WBACK && burst_done_i);
    assign burst_kind_o  = (in_lookup && victim_dirty_i) ? dcache_pkg::BURST_WBACK
                                                          : dcache_pkg::BURST_REFILL;
    assign burst_tag     = (burst_kind_o == dcache_pkg::BURST_WBACK) ? victim_tag_i : req_tag;
    assign line_addr_o   = {burst_tag, index, {`DC_OFFSET_W{1'b0}}};

    assign way_o       = hit_i ? hit_way_i : victim_way_i;  // miss side works on the victim
    assign hold_o      = (state_q != dcache_pkg::ST_IDLE);  // victim frozen during an access
    assign fill_sel_o  = (state_q == dcache_pkg::ST_REFILL);
    assign tag_we_o    = fill_sel_o && burst_done_i;        // refill line lands
    assign dirty_set_o = in_lookup && hit_i && req_i.we;    // store hit
    assign data_we_o   = tag_we_o || dirty_set_o;
    assign cpu_ack_o   = ack_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::ST_IDLE: begin
                if (cpu_req_valid_i) state_d = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_LOOKUP: begin
                if (hit_i)               state_d = dcache_pkg::ST_DONE;
                else if (victim_dirty_i) state_d = dcache_pkg::ST_WBACK;
                else                     state_d = dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_WBACK: begin
                if (burst_done_i) state_d = dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_REFILL: begin
                if (burst_done_i) state_d = dcache_pkg::ST_LOOKUP;  // retry as a hit
            end
            dcache_pkg::ST_DONE: begin
                state_d = cpu_req_valid_i ? dcache_pkg::ST_RELEASE : dcache_pkg::ST_IDLE;
            end
            dcache_pkg::ST_RELEASE: begin
                if (!cpu_req_valid_i) state_d = dcache_pkg::ST_IDLE;
            end
            default: state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= dcache_pkg::ST_IDLE;
            ack_q        <= 1'b0;
            missed_q     <= 1'b0;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            state_q <= state_d;
            if (in_lookup && hit_i) begin
                ack_q <= 1'b1;
                if (!missed_q) hit_count_o <= hit_count_o + 1'b1;  // not after a refill
            end
            if (in_lookup && !hit_i) begin
                missed_q     <= 1'b1;
                miss_count_o <= miss_count_o + 1'b1;
            end
            if (ack_q && !cpu_req_valid_i) ack_q <= 1'b0;  // req seen low
            if (state_d == dcache_pkg::ST_IDLE) missed_q <= 1'b0;
        end
    end

    // ack only belongs to a finished access
    a_ack_not_idle: assert property (@(posedge clk) disable iff (rst)
        !(cpu_ack_o && state_q == dcache_pkg::ST_IDLE))
        else $error("cpu ack high while idle");

    // one burst at a time, next start no earlier than the done of the last
    a_one_burst: assert property (@(posedge clk) disable iff (rst)
        burst_start_o |=> (!burst_start_o until burst_done_i))
        else $error("burst started while one is in progress");

endmodule

`default_nettype wire

/* dcache_top.sv */
////////////////////////////////////////
// data cache top level
// controller plus tag, data, align and memory port
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::cpu_req_t     cpu_req_i,
    input  logic                     cpu_req_valid_i,
    output logic                     cpu_ack_o,
    output logic [`DC_DATA_W-1:0]    cpu_rdata_o,
    output dcache_pkg::mem_req_t     mem_req_o,
    output logic                     mem_req_valid_o,
    input  logic                     mem_ack_i,
    input  logic [`DC_DATA_W-1:0]    mem_rdata_i,
    output logic [`DC_CNT_W-1:0]     hit_count_o,
    output logic [`DC_CNT_W-1:0]     miss_count_o
);
    logic hit, victim_dirty, burst_done, burst_start, hold;
    logic tag_we, dirty_set, data_we, fill_sel;
    logic [`DC_WAY_W-1:0]      hit_way, victim_way, way;
    logic [`DC_TAG_W-1:0]      victim_tag;
    logic [`DC_ADDR_W-1:0]     line_addr;
    dcache_pkg::dc_burst_e     burst_kind;
    logic [`DC_LINE_W/8-1:0]   byte_en;
    logic [`DC_LINE_W-1:0]     wline, line_rdata, refill_line;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req_i(cpu_req_i), .cpu_req_valid_i, .cpu_ack_o,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag), .burst_done_i(burst_done),
        .burst_start_o(burst_start), .burst_kind_o(burst_kind), .line_addr_o(line_addr),
        .way_o(way), .hold_o(hold), .tag_we_o(tag_we), .dirty_set_o(dirty_set),
        .data_we_o(data_we), .fill_sel_o(fill_sel), .hit_count_o, .miss_count_o
    );

    dcache_tag_array u_tag (
        .clk, .rst, .index_i(cpu_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .tag_i(cpu_req_i.addr[`DC_ADDR_W-1 -: `DC_TAG_W]), .we_i(tag_we), .way_i(way),
        .dirty_set_i(dirty_set), .dirty_clr_i(tag_we), .hold_i(hold), .hit_o(hit),
        .hit_way_o(hit_way), .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag)
    );

    dcache_data_array u_data (
        .clk, .index_i(cpu_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W]), .way_i(way),
        .we_i(data_we), .byte_en_i(byte_en), .wdata_i(wline), .rdata_o(line_rdata)
    );

    dcache_align u_align (
        .req_i(cpu_req_i), .line_i(line_rdata), .refill_line_i(refill_line),
        .fill_sel_i(fill_sel), .byte_en_o(byte_en), .wline_o(wline), .rdata_o(cpu_rdata_o)
    );

    dcache_mem_port u_mem_port (
        .clk, .rst, .start_i(burst_start), .kind_i(burst_kind), .line_addr_i(line_addr),
        .wb_line_i(line_rdata), .mem_req_o, .mem_req_valid_o, .mem_ack_i, .mem_rdata_i,
        .done_o(burst_done), .refill_line_o(refill_line)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
////////////////////////////////////////
// behavioral backing memory
// answers the four-phase beat handshake
// with a random 1 to 4 cycle ack delay
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module tb_mem_model #(
    parameter int DRIVE_DLY = 2   // ns after the rising edge
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::mem_req_t  mem_req_i,
    input  logic                  mem_req_valid_i,
    output logic                  mem_ack_o,
    output logic [`DC_DATA_W-1:0] mem_rdata_o
);
    logic [`DC_DATA_W-1:0] mem [logic [`DC_ADDR_W-1:0]];  // sparse, keyed by beat address
    integer                seed;

    // content of a beat never written, every address bit takes part
    function automatic logic [`DC_DATA_W-1:0] init_word(input logic [`DC_ADDR_W-1:0] baddr);
        return {baddr ^ 32'hc3a5_9e17, (baddr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c};
    endfunction

    initial begin
        seed        = 43449;
        mem_ack_o   = 1'b0;
        mem_rdata_o = '0;
    end

    always begin : responder
        dcache_pkg::mem_req_t  beat;
        logic [31:0]           r;
        logic [`DC_ADDR_W-1:0] key;
        @(posedge clk) #DRIVE_DLY;
        if (!rst && mem_req_valid_i) begin
            beat = mem_req_i;
            key  = {beat.addr[`DC_ADDR_W-1:3], 3'b000};
            r    = $random(seed);
            repeat (1 + r[1:0]) @(posedge clk) #DRIVE_DLY;  // memory latency
            if (beat.we) begin
                mem[key] = beat.wdata;         // write-back beat
            end else if (mem.exists(key)) begin
                mem_rdata_o = mem[key];
            end else begin
                mem_rdata_o = init_word(key);  // first touch
            end
            mem_ack_o = 1'b1;                  // rdata held while ack high
            while (mem_req_valid_i) @(posedge clk) #DRIVE_DLY;
            mem_ack_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
////////////////////////////////////////
// data cache testbench
// directed and random accesses checked
// against a shadow byte model
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "dcache_config.svh"

module tb_dcache;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int N_SUB      = 12;   // store rounds, one store and four loads each
    localparam int N_EVICT    = 4;    // lines sharing one set
    localparam int N_HS       = 4;    // loads with a slow req release
    localparam int N_MIX      = 200;
    localparam int N_ACCESS   = 2 + N_SUB * 5 + N_EVICT * 4 + N_HS + N_MIX;

    logic                  clk;
    logic                  rst;
    dcache_pkg::cpu_req_t  cpu_req;
    logic                  cpu_req_valid;
    logic                  cpu_ack;
    logic [`DC_DATA_W-1:0] cpu_rdata;
    dcache_pkg::mem_req_t  mem_req;
    logic                  mem_req_valid;
    logic                  mem_ack;
    logic [`DC_DATA_W-1:0] mem_rdata;
    logic [`DC_CNT_W-1:0]  hit_count;
    logic [`DC_CNT_W-1:0]  miss_count;

    logic [7:0]            shadow [logic [`DC_ADDR_W-1:0]];  // every byte the cpu stored
    logic                  expect_hit = 1'b0;                // next access must hit
    integer                seed = 43449;
    int                    errors = 0;
    int                    err_mark = 0;
    int                    tests = 0;
    int                    failed = 0;
    int                    accesses = 0;
    logic [`DC_ADDR_W-1:0] evict_line [N_EVICT];
    logic [`DC_ADDR_W-1:0] mix_line [8];

    dcache_top u_dcache_top (
        .clk, .rst, .cpu_req_i(cpu_req), .cpu_req_valid_i(cpu_req_valid), .cpu_ack_o(cpu_ack),
        .cpu_rdata_o(cpu_rdata), .mem_req_o(mem_req), .mem_req_valid_o(mem_req_valid),
        .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata), .hit_count_o(hit_count),
        .miss_count_o(miss_count)
    );

    tb_mem_model #(.DRIVE_DLY(DRIVE_DLY)) u_mem (
        .clk, .rst, .mem_req_i(mem_req), .mem_req_valid_i(mem_req_valid),
        .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // worst case miss with write-back is far below 60 cycles
    initial begin : watchdog
        #(N_ACCESS * 60 * CLK_PERIOD);
        $display("watchdog expired, a cpu access never completed");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        a_value: assert (got === exp)
            else flag_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // bytes from the shadow, else the memory's first-touch content
    function automatic logic [63:0] expect_load(input logic [31:0] addr, input int nbytes);
        logic [63:0] val;
        logic [63:0] word;
        logic [31:0] a;
        val = '0;  // zero extended
        for (int i = 0; i < nbytes; i++) begin
            a = addr + i;
            if (shadow.exists(a)) begin
                val[i*8 +: 8] = shadow[a];
            end else begin
                word          = u_mem.init_word({a[31:3], 3'b000});
                val[i*8 +: 8] = word[a[2:0]*8 +: 8];
            end
        end
        return val;
    endfunction

    function automatic logic [31:0] rand_line(input logic [3:0] set);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:8], set, 4'h0};  // random tag
    endfunction

    // one four-phase cpu transaction, linger keeps req up after ack
    task automatic do_access(input logic [31:0] addr, input logic we,
                             input dcache_pkg::dc_size_e size, input logic [63:0] wdata,
                             input int linger, output logic [63:0] rdata);
        cpu_req.addr  = addr;
        cpu_req.we    = we;
        cpu_req.size  = size;
        cpu_req.wdata = wdata;
        cpu_req_valid = 1'b1;
        @(posedge clk) #DRIVE_DLY;
        while (!cpu_ack) @(posedge clk) #DRIVE_DLY;
        rdata = cpu_rdata;
        repeat (linger) begin
            @(posedge clk) #DRIVE_DLY;
            check_eq("ack while req held", cpu_ack, 1'b1);
        end
        cpu_req_valid = 1'b0;
        while (cpu_ack) @(posedge clk) #DRIVE_DLY;
        accesses++;
    endtask

    task automatic store(input logic [31:0] addr, input dcache_pkg::dc_size_e size,
                         input logic [63:0] data);
        logic [63:0] unused;
        do_access(addr, 1'b1, size, data, 0, unused);
        for (int i = 0; i < (1 << size); i++) begin
            shadow[addr + i] = data[i*8 +: 8];
        end
    endtask

    task automatic load_check(input logic [31:0] addr, input dcache_pkg::dc_size_e size,
                              input int linger);
        logic [63:0] got;
        logic [63:0] exp;
        exp = expect_load(addr, 1 << size);
        do_access(addr, 1'b0, size, '0, linger, got);
        check_eq($sformatf("load %h size %0d", addr, 1 << size), got, exp);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ack is registered on the edge that saw req high
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cpu_ack) |-> $past(cpu_req_valid))
        else flag_error("cpu ack rose with no request");

    a_ack_release: assert property (@(posedge clk) disable iff (rst)
        $fell(cpu_req_valid) |=> !cpu_ack)
        else flag_error("cpu ack still high a cycle after req fell");

    a_mem_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && $past(mem_req_valid)) |-> (mem_req === $past(mem_req)))
        else flag_error("memory request changed while valid");

    a_wb_addr: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && mem_req.we) |-> (mem_req.addr[2:0] == 3'b000))
        else flag_error("write-back beat not at line + 0 or + 8");

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (expect_hit && $rose(cpu_req_valid)) |-> ##2 $rose(cpu_ack))
        else flag_error("hit ack not exactly two cycles after req");

    a_hit_no_mem: assert property (@(posedge clk) disable iff (rst)
        (expect_hit && cpu_req_valid) |-> !mem_req_valid)
        else flag_error("memory traffic during a hit");

    initial begin : stimulus
        logic [31:0]          line;
        logic [31:0]          addr;
        logic [31:0]          r;
        logic [3:0]           off;
        dcache_pkg::dc_size_e sz;
        int                   nb;
        rst           = 1'b1;
        cpu_req       = '0;
        cpu_req_valid = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY rst = 1'b0;

        check_eq("ack after reset", cpu_ack, 1'b0);
        check_eq("mem valid after reset", mem_req_valid, 1'b0);
        check_eq("hit count after reset", hit_count, 0);
        check_eq("miss count after reset", miss_count, 0);
        end_test("reset");

        line = rand_line(4'h3);  // cold line, then the same read as a hit
        load_check(line, dcache_pkg::SZ_D, 0);
        check_eq("miss count after cold read", miss_count, 1);
        check_eq("hit count after cold read", hit_count, 0);
        expect_hit = 1'b1;
        load_check(line, dcache_pkg::SZ_D, 0);
        expect_hit = 1'b0;
        check_eq("hit count after second read", hit_count, 1);
        check_eq("miss count after second read", miss_count, 1);
        end_test("miss_hit");

        for (int i = 0; i < N_SUB; i++) begin
            r    = $random(seed);
            sz   = dcache_pkg::dc_size_e'(r[5:4] % 3);  // byte, half or word
            nb   = 1 << sz;
            off  = r[3:0] & ~(4'(nb) - 4'd1);
            addr = rand_line(r[9:6]) + off;
            store(addr, sz, {$random(seed), $random(seed)});
            for (int s = 0; s < 4; s++) begin
                load_check(addr & ~(32'(1 << s) - 1), dcache_pkg::dc_size_e'(s), 0);
            end
        end
        end_test("subword");

        // four dirty lines in one 2-way set
        for (int i = 0; i < N_EVICT; i++) begin
            evict_line[i] = rand_line(4'h9);
            store(evict_line[i], dcache_pkg::SZ_D, {$random(seed), $random(seed)});
            store(evict_line[i] + 8, dcache_pkg::SZ_D, {$random(seed), $random(seed)});
        end
        for (int i = 0; i < N_EVICT; i++) begin
            load_check(evict_line[i], dcache_pkg::SZ_D, 0);
            load_check(evict_line[i] + 8, dcache_pkg::SZ_D, 0);
        end
        end_test("eviction");

        for (int i = 0; i < N_HS; i++) begin
            load_check(evict_line[i] + 4, dcache_pkg::SZ_W, i + 1);  // slow cpu
        end
        end_test("handshake");

        for (int i = 0; i < 8; i++) begin
            mix_line[i] = rand_line(4'(i % 4) + 4'hc);  // two lines per set
        end
        for (int i = 0; i < N_MIX; i++) begin
            r    = $random(seed);
            sz   = dcache_pkg::dc_size_e'(r[5:4]);
            nb   = 1 << sz;
            off  = r[3:0] & ~(4'(nb) - 4'd1);
            addr = mix_line[r[10:8]] + off;
            if (r[6]) begin
                store(addr, sz, {$random(seed), $random(seed)});
            end else begin
                load_check(addr, sz, 0);
            end
        end
        check_eq("hit plus miss count", hit_count + miss_count, accesses);
        end_test("random_mix");

        $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_align.sv
dcache_mem_port.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
